// ==== hdl/cl_pkg.sv ====
/*
 * Shared widths, fixed burst constants and bus structs for the custom-logic
 * glue. Modules pull these in with a wildcard import in their body and use
 * scoped names in their port lists.
 */
package cl_pkg;

  // Channel count is fixed, the status word layout holds four channels
  localparam int NUM_CHAN     = 4;
  localparam int MEM_ADDR_W   = 64;
  localparam int MEM_DATA_W   = 512;
  localparam int MEM_STRB_W   = MEM_DATA_W / 8;
  localparam int MEM_ID_W     = 16;
  localparam int MEM_LEN_W    = 8;
  localparam int MEM_SIZE_W   = 3;
  localparam int MEM_RESP_W   = 2;
  localparam int SCRB_STATE_W = 3;

  // AXI size code for 64-byte beats
  localparam logic [MEM_SIZE_W-1:0] FULL_BURST_SIZE = 3'b110;

  // ------------------------------------------------------------
  // Memory controller request and response
  // ------------------------------------------------------------
  typedef struct packed {
    logic                  awvalid;
    logic [MEM_ADDR_W-1:0] awaddr;
    logic [MEM_ID_W-1:0]   awid;
    logic [MEM_LEN_W-1:0]  awlen;
    logic [MEM_SIZE_W-1:0] awsize;
    logic                  wvalid;
    logic [MEM_DATA_W-1:0] wdata;
    logic [MEM_STRB_W-1:0] wstrb;
    logic                  wlast;
    logic [MEM_ID_W-1:0]   wid;
    logic                  bready;
    logic                  arvalid;
    logic [MEM_ADDR_W-1:0] araddr;
    logic [MEM_ID_W-1:0]   arid;
    logic [MEM_LEN_W-1:0]  arlen;
    logic [MEM_SIZE_W-1:0] arsize;
    logic                  rready;
  } mem_req_t;

  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [MEM_ID_W-1:0]   bid;
    logic [MEM_RESP_W-1:0] bresp;
    logic                  arready;
    logic                  rvalid;
    logic [MEM_ID_W-1:0]   rid;
    logic [MEM_DATA_W-1:0] rdata;
    logic [MEM_RESP_W-1:0] rresp;
    logic                  rlast;
  } mem_rsp_t;

  // ------------------------------------------------------------
  // Streaming engine side
  // ------------------------------------------------------------
  typedef struct packed {
    logic [MEM_ADDR_W-1:0] araddr;
    logic [MEM_LEN_W-1:0]  arlen;
    logic                  arvalid;
    logic                  rready;
    logic [MEM_ADDR_W-1:0] awaddr;
    logic [MEM_LEN_W-1:0]  awlen;
    logic [MEM_ID_W-1:0]   awid;
    logic                  awvalid;
    logic [MEM_DATA_W-1:0] wdata;
    logic                  wvalid;
    logic                  wlast;
  } eng_req_t;

  typedef struct packed {
    logic                  arready;
    logic                  rvalid;
    logic [MEM_DATA_W-1:0] rdata;
    logic                  awready;
    logic                  wready;
  } eng_rsp_t;

  // One channel of scrubber status
  typedef struct packed {
    logic [SCRB_STATE_W-1:0] state;
    logic [MEM_ADDR_W-1:0]   addr;
    logic                    done;
  } scrb_stat_t;

  typedef enum logic [1:0] {
    HOST_OWNS    = 2'd0,
    ENGINE_RESET = 2'd1,
    ENGINE_OWNS  = 2'd2
  } handover_state_e;

endpackage

// ==== hdl/host_ctrl_regs.sv ====
/*
 * Host control and status registers. Captures the control word, builds the
 * status and identity words with an optional scrubber debug view, and
 * answers the function-level reset with a one-cycle done pulse.
 */
`timescale 1ns/1ps

module host_ctrl_regs #(
  parameter logic [31:0] CL_ID0     = 32'hF000_1D0F,
  parameter logic [31:0] CL_ID1     = 32'h1D51_FEDD,
  parameter logic [31:0] CL_VERSION = 32'hEEEE_EE00
) (
  input  logic               clk,
  input  logic               sync_rst_n,
  input  logic [31:0]        ctl0,
  input  cl_pkg::scrb_stat_t scrb_stat [cl_pkg::NUM_CHAN],
  input  logic [3:0]         mem_ready,
  input  logic               flr_assert,
  output logic [3:0]         scrb_enable,
  output logic [31:0]        status0,
  output logic [31:0]        status1,
  output logic [31:0]        id0,
  output logic [31:0]        id1,
  output logic               flr_done
);

  import cl_pkg::*;

  localparam logic [19:0] STATUS_PREFIX = 20'hA1111;
  localparam int          SEL_W         = $clog2(NUM_CHAN);

  logic [31:0]           ctl0_q;
  logic                  dbg_en;
  logic [2:0]            dbg_sel;
  logic [SEL_W-1:0]      sel_chan;
  logic [MEM_ADDR_W-1:0] sel_addr;
  logic [15:0]           dbg_states;
  logic [3:0]            done_bits;
  logic                  flr_assert_q;

  // ------------------------------------------------------------
  // Control word
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      ctl0_q <= 32'd0;
    end else begin
      ctl0_q <= ctl0;
    end
  end

  // Bits 3..0 enable the scrubbers of channels 3..0
  assign scrb_enable = ctl0_q[3:0];
  assign dbg_en      = ctl0_q[31];
  assign dbg_sel     = ctl0_q[30:28];

  // Out of range selects fall back to channel 0
  assign sel_chan = (dbg_sel < NUM_CHAN) ? dbg_sel[SEL_W-1:0] : '0;
  assign sel_addr = scrb_stat[sel_chan].addr;

  // One nibble per channel, zero bit above the scrubber state
  always_comb begin
    for (int i = 0; i < NUM_CHAN; i++) begin
      dbg_states[i*4 +: 4] = {1'b0, scrb_stat[i].state};
      done_bits[i]         = scrb_stat[i].done;
    end
  end

  // ------------------------------------------------------------
  // Status and identity words
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (dbg_en) begin
      status0 <= {dbg_states, 4'h0, 4'hF, done_bits, mem_ready};
      id0     <= sel_addr[31:0];
      id1     <= sel_addr[63:32];
    end else begin
      status0 <= {STATUS_PREFIX, 4'hF, done_bits, mem_ready};
      id0     <= CL_ID0;
      id1     <= CL_ID1;
    end
  end

  assign status1 = CL_VERSION;

  // ------------------------------------------------------------
  // FLR response
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end else begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end
  end

  // Done is a pulse, even for a held FLR request
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    flr_done |=> !flr_done)
    else $error("flr_done held high for two cycles");

endmodule

// ==== hdl/stream_handover.sv ====
/*
 * Handover of the memory ports from the host DMA path to the streaming
 * engine. The engine gets a one-cycle reset, then owns the ports until
 * it reports that it has finished.
 */
`timescale 1ns/1ps

module stream_handover (
  input  logic clk,
  input  logic sync_rst_n,
  input  logic stream_start,
  input  logic engine_finished,
  output logic engine_reset,
  output logic engine_grant,
  output logic stream_done
);

  import cl_pkg::*;

  handover_state_e state_q;
  handover_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      HOST_OWNS: begin
        if (stream_start) begin
          state_d = ENGINE_RESET;
        end
      end
      // Reset lasts a single cycle
      ENGINE_RESET: state_d = ENGINE_OWNS;
      ENGINE_OWNS: begin
        if (engine_finished) begin
          state_d = HOST_OWNS;
        end
      end
      default: state_d = HOST_OWNS;
    endcase
  end

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      state_q <= HOST_OWNS;
    end else begin
      state_q <= state_d;
    end
  end

  assign engine_reset = (state_q == ENGINE_RESET);
  assign engine_grant = (state_q == ENGINE_OWNS);
  // Done is seen in the same cycle as finished
  assign stream_done  = engine_grant && engine_finished;

  // The engine always comes out of reset owning the ports
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    engine_reset |=> engine_grant)
    else $error("engine_reset not followed by engine_grant");

endmodule

// ==== hdl/mem_port_mux.sv ====
/*
 * Memory port steering for one channel. With the grant low the host DMA
 * path owns the controller; with it high the streaming engine does. No
 * registers on the path, valid and ready pass straight through.
 */
`timescale 1ns/1ps

module mem_port_mux (
  input  logic             clk,
  input  logic             sync_rst_n,
  input  logic             engine_grant,
  input  cl_pkg::mem_req_t host_req,
  input  cl_pkg::eng_req_t eng_req,
  input  cl_pkg::mem_rsp_t mem_rsp,
  output cl_pkg::mem_req_t mem_req,
  output cl_pkg::mem_rsp_t host_rsp,
  output cl_pkg::eng_rsp_t eng_rsp
);

  import cl_pkg::*;

  // ------------------------------------------------------------
  // Request toward the controller
  // ------------------------------------------------------------
  always_comb begin
    mem_req = host_req;
    if (engine_grant) begin
      mem_req.awvalid = eng_req.awvalid;
      mem_req.awaddr  = eng_req.awaddr;
      mem_req.awid    = eng_req.awid;
      mem_req.awlen   = eng_req.awlen;
      mem_req.awsize  = FULL_BURST_SIZE;
      mem_req.wvalid  = eng_req.wvalid;
      mem_req.wdata   = eng_req.wdata;
      mem_req.wstrb   = '1;
      mem_req.wlast   = eng_req.wlast;
      mem_req.wid     = '0;
      // Engine never stalls write responses
      mem_req.bready  = 1'b1;
      mem_req.arvalid = eng_req.arvalid;
      mem_req.araddr  = eng_req.araddr;
      mem_req.arid    = '0;
      mem_req.arlen   = eng_req.arlen;
      mem_req.arsize  = FULL_BURST_SIZE;
      mem_req.rready  = eng_req.rready;
    end
  end

  // ------------------------------------------------------------
  // Responses back to host and engine
  // ------------------------------------------------------------
  always_comb begin
    // rdata, bid, bresp and rid go to the host unchanged
    host_rsp = mem_rsp;
    if (engine_grant) begin
      host_rsp.awready = 1'b0;
      host_rsp.wready  = 1'b0;
      host_rsp.bvalid  = 1'b0;
      host_rsp.arready = 1'b0;
      host_rsp.rvalid  = 1'b0;
      host_rsp.rresp   = '0;
      host_rsp.rlast   = 1'b0;
    end
  end

  always_comb begin
    eng_rsp.rdata   = mem_rsp.rdata;
    eng_rsp.arready = engine_grant && mem_rsp.arready;
    eng_rsp.rvalid  = engine_grant && mem_rsp.rvalid;
    eng_rsp.awready = engine_grant && mem_rsp.awready;
    eng_rsp.wready  = engine_grant && mem_rsp.wready;
  end

  // Only one owner may see an address accepted
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    !(host_rsp.arready && eng_rsp.arready) && !(host_rsp.awready && eng_rsp.awready))
    else $error("address ready seen by host and engine together");

endmodule

// ==== hdl/cl_stream_top.sv ====
/*
 * Custom-logic glue top level. Ties the host register block and the
 * engine handover controller to one port multiplexer per memory channel.
 */
`timescale 1ns/1ps

module cl_stream_top #(
  parameter logic [31:0] CL_ID0     = 32'hF000_1D0F,
  parameter logic [31:0] CL_ID1     = 32'h1D51_FEDD,
  parameter logic [31:0] CL_VERSION = 32'hEEEE_EE00
) (
  input  logic               clk,
  input  logic               sync_rst_n,

  // Host registers and scrubber status
  input  logic [31:0]        ctl0,
  input  cl_pkg::scrb_stat_t scrb_stat [cl_pkg::NUM_CHAN],
  input  logic [3:0]         mem_ready,
  input  logic               flr_assert,
  output logic [3:0]         scrb_enable,
  output logic [31:0]        status0,
  output logic [31:0]        status1,
  output logic [31:0]        id0,
  output logic [31:0]        id1,
  output logic               flr_done,

  // Engine control
  input  logic               stream_start,
  input  logic               engine_finished,
  output logic               engine_reset,
  output logic               stream_done,

  // Memory paths, one element per channel
  input  cl_pkg::mem_req_t   host_req [cl_pkg::NUM_CHAN],
  output cl_pkg::mem_rsp_t   host_rsp [cl_pkg::NUM_CHAN],
  input  cl_pkg::eng_req_t   eng_req  [cl_pkg::NUM_CHAN],
  output cl_pkg::eng_rsp_t   eng_rsp  [cl_pkg::NUM_CHAN],
  output cl_pkg::mem_req_t   mem_req  [cl_pkg::NUM_CHAN],
  input  cl_pkg::mem_rsp_t   mem_rsp  [cl_pkg::NUM_CHAN]
);

  import cl_pkg::*;

  logic engine_grant;

  host_ctrl_regs #(
    .CL_ID0     (CL_ID0),
    .CL_ID1     (CL_ID1),
    .CL_VERSION (CL_VERSION)
  ) u_host_ctrl_regs (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .ctl0        (ctl0),
    .scrb_stat   (scrb_stat),
    .mem_ready   (mem_ready),
    .flr_assert  (flr_assert),
    .scrb_enable (scrb_enable),
    .status0     (status0),
    .status1     (status1),
    .id0         (id0),
    .id1         (id1),
    .flr_done    (flr_done)
  );

  stream_handover u_stream_handover (
    .clk             (clk),
    .sync_rst_n      (sync_rst_n),
    .stream_start    (stream_start),
    .engine_finished (engine_finished),
    .engine_reset    (engine_reset),
    .engine_grant    (engine_grant),
    .stream_done     (stream_done)
  );

  // ------------------------------------------------------------
  // One multiplexer per memory channel, all on the same grant
  // ------------------------------------------------------------
  for (genvar ch = 0; ch < NUM_CHAN; ch++) begin : g_chan
    mem_port_mux u_mem_port_mux (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .engine_grant (engine_grant),
      .host_req     (host_req[ch]),
      .eng_req      (eng_req[ch]),
      .mem_rsp      (mem_rsp[ch]),
      .mem_req      (mem_req[ch]),
      .host_rsp     (host_rsp[ch]),
      .eng_rsp      (eng_rsp[ch])
    );
  end

endmodule

// ==== tests/tb_vectors.svh ====
/*
 * Register stimulus table for the custom-logic testbench. Included inside
 * the testbench module; each row is driven and checked two cycles later.
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [31:0] TB_CL_ID0     = 32'h1D0F_C0DE;
localparam logic [31:0] TB_CL_ID1     = 32'hFEED_5EED;
localparam logic [31:0] TB_CL_VERSION = 32'h0002_0104;

// Columns: ctl0, states ch3..ch0, addrs ch3..ch0, done, mem_ready,
// expected status0, id0, id1
typedef struct packed {
  logic [31:0]  ctl0;
  logic [11:0]  states;
  logic [255:0] addrs;
  logic [3:0]   done;
  logic [3:0]   ready;
  logic [31:0]  exp_status0;
  logic [31:0]  exp_id0;
  logic [31:0]  exp_id1;
} reg_vec_t;

localparam int NUM_VECS = 7;

localparam reg_vec_t REG_VECS [NUM_VECS] = '{
  '{32'h0000_0000, {3'd0, 3'd0, 3'd0, 3'd0}, {4{64'h0}}, 4'b0000, 4'b0000,
    32'hA111_1F00, TB_CL_ID0, TB_CL_ID1},
  '{32'h0000_000F, {3'd1, 3'd2, 3'd3, 3'd4},
    {64'h0000_0001_0000_0000, 64'h0000_0000_0000_1000,
     64'h0000_0000_0000_0100, 64'h0000_0000_0000_0010},
    4'b1010, 4'b1111, 32'hA111_1FAF, TB_CL_ID0, TB_CL_ID1},
  // Debug view of channel 0
  '{32'h8000_0005, {3'd5, 3'd1, 3'd7, 3'd2},
    {64'h0000_0033_0000_3300, 64'h0000_0022_0000_2200,
     64'h0000_0011_0000_1100, 64'h0000_00AB_CDEF_0040},
    4'b0011, 4'b1100, 32'h5172_0F3C, 32'hCDEF_0040, 32'h0000_00AB},
  '{32'hA000_0003, {3'd0, 3'd6, 3'd3, 3'd1},
    {64'h0000_0003_1000_0000, 64'h0000_0017_8000_0C00,
     64'h0000_0001_0000_0040, 64'h0000_0000_0000_0080},
    4'b0100, 4'b0110, 32'h0631_0F46, 32'h8000_0C00, 32'h0000_0017},
  '{32'hB000_0008, {3'd7, 3'd7, 3'd7, 3'd7},
    {64'h0000_003F_FFFF_FFC0, 64'h0000_0004_0000_0000,
     64'h0000_0005_0000_0000, 64'h0000_0006_0000_0000},
    4'b1111, 4'b0001, 32'h7777_0FF1, 32'hFFFF_FFC0, 32'h0000_003F},
  // Select 7 is out of range and falls back to channel 0
  '{32'hF000_0001, {3'd4, 3'd0, 3'd2, 3'd0},
    {64'h0000_0009_9000_0000, 64'h0000_0008_8000_0000,
     64'h0000_0007_7000_0000, 64'h0000_0002_4000_0100},
    4'b0000, 4'b0000, 32'h4020_0F00, 32'h4000_0100, 32'h0000_0002},
  '{32'h7000_0002, {3'd3, 3'd3, 3'd3, 3'd3},
    {64'h0000_0000_DEAD_0000, 64'h1, 64'h2, 64'h3},
    4'b0101, 4'b1010, 32'hA111_1F5A, TB_CL_ID0, TB_CL_ID1}
};

`endif

// ==== tests/tb_cl_stream_top.sv ====
/*
 * Testbench for the custom-logic glue top level. Covers reset state, the
 * host passthrough, the register table, FLR and the engine handover.
 */
`timescale 1ns/1ps

module tb_cl_stream_top;

  import cl_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;

  `include "tb_vectors.svh"

  logic        clk;
  logic        sync_rst_n;
  logic [31:0] ctl0;
  scrb_stat_t  scrb_stat [NUM_CHAN];
  logic [3:0]  mem_ready;
  logic        flr_assert;
  logic        stream_start;
  logic        engine_finished;
  logic [3:0]  scrb_enable;
  logic [31:0] status0;
  logic [31:0] status1;
  logic [31:0] id0;
  logic [31:0] id1;
  logic        flr_done;
  logic        engine_reset;
  logic        stream_done;
  mem_req_t    host_req [NUM_CHAN];
  mem_rsp_t    host_rsp [NUM_CHAN];
  eng_req_t    eng_req  [NUM_CHAN];
  eng_rsp_t    eng_rsp  [NUM_CHAN];
  mem_req_t    mem_req  [NUM_CHAN];
  mem_rsp_t    mem_rsp  [NUM_CHAN];
  integer      seed;
  bit          seen;

  cl_stream_top #(
    .CL_ID0     (TB_CL_ID0),
    .CL_ID1     (TB_CL_ID1),
    .CL_VERSION (TB_CL_VERSION)
  ) uut (
    .clk             (clk),
    .sync_rst_n      (sync_rst_n),
    .ctl0            (ctl0),
    .scrb_stat       (scrb_stat),
    .mem_ready       (mem_ready),
    .flr_assert      (flr_assert),
    .scrb_enable     (scrb_enable),
    .status0         (status0),
    .status1         (status1),
    .id0             (id0),
    .id1             (id1),
    .flr_done        (flr_done),
    .stream_start    (stream_start),
    .engine_finished (engine_finished),
    .engine_reset    (engine_reset),
    .stream_done     (stream_done),
    .host_req        (host_req),
    .host_rsp        (host_rsp),
    .eng_req         (eng_req),
    .eng_rsp         (eng_rsp),
    .mem_req         (mem_req),
    .mem_rsp         (mem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reporting and random helpers
  // ------------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input logic [1023:0] actual, input logic [1023:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at time %0t: %s mismatch, got %0h, expected %0h",
               $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic fill_random(output logic [511:0] v);
    for (int i = 0; i < 16; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
  endtask

  task automatic init_inputs();
    ctl0            = '0;
    mem_ready       = '0;
    flr_assert      = 1'b0;
    stream_start    = 1'b0;
    engine_finished = 1'b0;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      scrb_stat[ch] = '0;
      host_req[ch]  = '0;
      eng_req[ch]   = '0;
      mem_rsp[ch]   = '0;
    end
  endtask

  // ------------------------------------------------------------
  // Host path
  // ------------------------------------------------------------
  task automatic drive_host_traffic();
    logic [511:0] r;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      fill_random(r);
      host_req[ch]         = '0;
      host_req[ch].arvalid = 1'b1;
      host_req[ch].araddr  = r[63:0];
      host_req[ch].arid    = r[79:64];
      host_req[ch].arlen   = r[87:80];
      host_req[ch].arsize  = r[90:88];
      host_req[ch].rready  = 1'b1;
      fill_random(r);
      mem_rsp[ch]         = '0;
      mem_rsp[ch].awready = 1'b1;
      mem_rsp[ch].wready  = 1'b1;
      mem_rsp[ch].bvalid  = 1'b1;
      mem_rsp[ch].arready = 1'b1;
      mem_rsp[ch].rvalid  = 1'b1;
      mem_rsp[ch].rid     = r[15:0];
      mem_rsp[ch].rresp   = r[17:16];
      mem_rsp[ch].rlast   = r[18];
      mem_rsp[ch].rdata   = r;
    end
  endtask

  task automatic check_host_path();
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      check_value(mem_req[ch], host_req[ch], $sformatf("ch%0d mem_req passthrough", ch));
      check_value(host_rsp[ch], mem_rsp[ch], $sformatf("ch%0d host_rsp passthrough", ch));
      check_value({eng_rsp[ch].arready, eng_rsp[ch].rvalid, eng_rsp[ch].awready,
                   eng_rsp[ch].wready}, 4'b0000, $sformatf("ch%0d eng_rsp idle", ch));
      check_value(eng_rsp[ch].rdata, mem_rsp[ch].rdata, $sformatf("ch%0d eng rdata", ch));
    end
  endtask

  // ------------------------------------------------------------
  // Engine path
  // ------------------------------------------------------------
  task automatic drive_engine_traffic();
    logic [511:0] r;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      fill_random(r);
      eng_req[ch].araddr  = r[63:0];
      eng_req[ch].arlen   = r[71:64];
      eng_req[ch].arvalid = 1'b1;
      eng_req[ch].rready  = 1'b1;
      eng_req[ch].awaddr  = r[135:72];
      eng_req[ch].awlen   = r[143:136];
      eng_req[ch].awid    = r[159:144];
      eng_req[ch].awvalid = 1'b1;
      eng_req[ch].wvalid  = 1'b1;
      eng_req[ch].wlast   = r[160];
      fill_random(r);
      eng_req[ch].wdata   = r;
    end
  endtask

  task automatic check_engine_request();
    mem_req_t exp;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      exp.awvalid = eng_req[ch].awvalid;
      exp.awaddr  = eng_req[ch].awaddr;
      exp.awid    = eng_req[ch].awid;
      exp.awlen   = eng_req[ch].awlen;
      exp.awsize  = cl_pkg::FULL_BURST_SIZE;
      exp.wvalid  = eng_req[ch].wvalid;
      exp.wdata   = eng_req[ch].wdata;
      exp.wstrb   = '1;
      exp.wlast   = eng_req[ch].wlast;
      exp.wid     = '0;
      exp.bready  = 1'b1;
      exp.arvalid = eng_req[ch].arvalid;
      exp.araddr  = eng_req[ch].araddr;
      exp.arid    = '0;
      exp.arlen   = eng_req[ch].arlen;
      exp.arsize  = cl_pkg::FULL_BURST_SIZE;
      exp.rready  = eng_req[ch].rready;
      check_value(mem_req[ch], exp, $sformatf("ch%0d mem_req from engine", ch));
    end
  endtask

  task automatic drive_engine_responses();
    logic [511:0] r;
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      fill_random(r);
      mem_rsp[ch].awready = 1'b1;
      mem_rsp[ch].wready  = 1'b1;
      mem_rsp[ch].bvalid  = 1'b1;
      mem_rsp[ch].arready = 1'b1;
      mem_rsp[ch].rvalid  = 1'b1;
      mem_rsp[ch].rlast   = 1'b1;
      mem_rsp[ch].rresp   = 2'b01;
      mem_rsp[ch].bid     = r[15:0];
      mem_rsp[ch].bresp   = r[17:16];
      mem_rsp[ch].rid     = r[33:18];
      mem_rsp[ch].rdata   = r;
    end
  endtask

  task automatic check_engine_responses();
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      check_value({host_rsp[ch].awready, host_rsp[ch].wready, host_rsp[ch].bvalid,
                   host_rsp[ch].arready, host_rsp[ch].rvalid, host_rsp[ch].rresp,
                   host_rsp[ch].rlast}, 8'h00, $sformatf("ch%0d host_rsp gated", ch));
      check_value({host_rsp[ch].bid, host_rsp[ch].bresp, host_rsp[ch].rid},
                  {mem_rsp[ch].bid, mem_rsp[ch].bresp, mem_rsp[ch].rid},
                  $sformatf("ch%0d host ids", ch));
      check_value(host_rsp[ch].rdata, mem_rsp[ch].rdata, $sformatf("ch%0d host rdata", ch));
      check_value({eng_rsp[ch].arready, eng_rsp[ch].rvalid, eng_rsp[ch].awready,
                   eng_rsp[ch].wready},
                  {mem_rsp[ch].arready, mem_rsp[ch].rvalid, mem_rsp[ch].awready,
                   mem_rsp[ch].wready}, $sformatf("ch%0d eng_rsp readies", ch));
      check_value(eng_rsp[ch].rdata, mem_rsp[ch].rdata, $sformatf("ch%0d eng rdata", ch));
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    seed       = 32'h6b58_5b39;
    sync_rst_n = 1'b0;
    init_inputs();
    repeat (8) @(negedge clk);
    sync_rst_n = 1'b1;

    // Idle state and host passthrough
    @(negedge clk);
    check_value({engine_reset, stream_done, flr_done}, 3'b000, "reset outputs");
    check_value(scrb_enable, 4'h0, "scrb_enable after reset");
    drive_host_traffic();
    #1;
    check_host_path();

    // Register table
    for (int v = 0; v < NUM_VECS; v++) begin
      @(negedge clk);
      ctl0      = REG_VECS[v].ctl0;
      mem_ready = REG_VECS[v].ready;
      for (int ch = 0; ch < NUM_CHAN; ch++) begin
        scrb_stat[ch].state = REG_VECS[v].states[ch*3 +: 3];
        scrb_stat[ch].addr  = REG_VECS[v].addrs[ch*64 +: 64];
        scrb_stat[ch].done  = REG_VECS[v].done[ch];
      end
      repeat (2) @(negedge clk);
      check_value(status0, REG_VECS[v].exp_status0, $sformatf("row %0d status0", v));
      check_value(id0, REG_VECS[v].exp_id0, $sformatf("row %0d id0", v));
      check_value(id1, REG_VECS[v].exp_id1, $sformatf("row %0d id1", v));
      check_value(status1, TB_CL_VERSION, $sformatf("row %0d status1", v));
      check_value(scrb_enable, REG_VECS[v].ctl0[3:0], $sformatf("row %0d scrb_enable", v));
    end

    // FLR pulse gives done on the second cycle only
    @(negedge clk);
    flr_assert = 1'b1;
    for (int c = 1; c <= 6; c++) begin
      @(negedge clk);
      flr_assert = 1'b0;
      check_value(flr_done, (c == 2), $sformatf("flr_done cycle %0d", c));
    end

    // Handover to the engine
    @(negedge clk);
    drive_engine_traffic();
    stream_start = 1'b1;
    seen         = 1'b0;
    for (int i = 0; i < TIMEOUT_CYCLES && !seen; i++) begin
      @(negedge clk);
      seen = engine_reset;
    end
    if (!seen) begin
      $display("Timed out waiting for engine_reset after stream_start");
      abort_run();
    end
    stream_start = 1'b0;
    @(negedge clk);
    check_value(engine_reset, 1'b0, "engine_reset pulse width");
    check_engine_request();
    drive_engine_responses();
    #1;
    check_engine_responses();

    // Finish and return to the host
    @(negedge clk);
    engine_finished = 1'b1;
    #1;
    check_value(stream_done, 1'b1, "stream_done with engine_finished");
    @(negedge clk);
    engine_finished = 1'b0;
    drive_host_traffic();
    #1;
    check_value({stream_done, engine_reset}, 2'b00, "outputs after return");
    check_host_path();

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tests
hdl/cl_pkg.sv
hdl/host_ctrl_regs.sv
hdl/stream_handover.sv
hdl/mem_port_mux.sv
hdl/cl_stream_top.sv
tests/tb_cl_stream_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

mkdir -p build
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cl_stream_top \
  -f compile.f \
  -Mdir build/obj_dir -o sim_tb

./build/obj_dir/sim_tb 2>&1 | tee build/sim.log

if grep -q "TEST FAIL" build/sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
